/* Bender.yml */
package:
  name: tl_burst_monitor

sources:
  # Package first, then the RTL bottom up
  - design/tl_mon_pkg.sv
  - design/tl_chan_decode.sv
  - design/tl_beat_tracker.sv
  - design/tl_msg_counter.sv
  - design/tl_burst_monitor.sv
  - target: simulation
    files:
      - testbench/tb_tl_burst_monitor.sv

/* build.f */
design/tl_mon_pkg.sv
design/tl_chan_decode.sv
design/tl_beat_tracker.sv
design/tl_msg_counter.sv
design/tl_burst_monitor.sv
testbench/tb_tl_burst_monitor.sv

/* design/tl_beat_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tl_beat_tracker import tl_mon_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,

  // One beat of this channel is transferred
  input  wire logic                     fire_i,
  // Burst length of the message on the wires, beats minus one
  input  wire logic [BurstLenWidth-1:0] len_i,

  // Index of the beat on the wires within its message
  output logic      [BurstLenWidth-1:0] idx_o,
  // Beats still to come after the one on the wires
  output logic      [BurstLenWidth-1:0] left_o,
  // The beat on the wires opens a message
  output logic                          first_o,
  // The beat on the wires closes a message
  output logic                          last_o
);

  //////////////////////////////
  // Beats-left register
  //////////////////////////////

  // Between messages the register sits at all ones
  // The length of the next message is unknown until its first beat shows up,
  // so all ones stands in for it and the mask with len_i recovers the real value
  // Inside a message left_q is already no larger than len_i and the mask
  // leaves it unchanged, so first and later beats share one expression
  logic [BurstLenWidth-1:0] left_q;

  //////////////////////////////
  // Beat position
  //////////////////////////////

  // Beats left after this one
  assign left_o = len_i & left_q;

  // The index is len minus left
  // Since left is a submask of len here, the difference is just the bits of
  // len that left does not have, so no subtractor sits on this path
  assign idx_o = len_i & ~left_q;

  // All ones only occurs between messages, so this is the opening beat
  assign first_o = &left_q;

  // Nothing left after this beat
  assign last_o = left_o == '0;

  //////////////////////////////
  // Update on a fire
  //////////////////////////////

  // Each fire counts one beat down
  // After the last beat left_o is zero and the decrement wraps back to all ones,
  // which leaves the register ready for the next message with no extra logic
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      left_q <= '1;
    end else if (fire_i) begin
      left_q <= left_o - 1'b1;
    end
  end

  // Outside a fire the outputs describe the beat that would fire next
  // A gap between beats therefore leaves them unchanged as long as the
  // header fields are held

endmodule

`default_nettype wire

/* design/tl_burst_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tl_burst_monitor import tl_mon_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  // Beat strobes from the link owner, one per transferred beat
  input  wire logic                      a_fire_i,
  input  wire logic                      c_fire_i,
  input  wire logic                      d_fire_i,

  // Header fields, valid while the matching fire is high
  input  wire logic [OpcodeWidth-1:0]    a_opcode_i,
  input  wire logic [SizeWidth-1:0]      a_size_i,
  input  wire logic [OpcodeWidth-1:0]    c_opcode_i,
  input  wire logic [SizeWidth-1:0]      c_size_i,
  input  wire logic [OpcodeWidth-1:0]    d_opcode_i,
  input  wire logic [SizeWidth-1:0]      d_size_i,

  // Position of the beat on the wires, indexed by ChanA, ChanC and ChanD
  output logic      [BurstLenWidth-1:0]  beat_idx_o   [NumChan],
  output logic      [BurstLenWidth-1:0]  beat_left_o  [NumChan],
  output logic                           beat_first_o [NumChan],
  output logic                           beat_last_o  [NumChan],

  // Message completion reporting, one lane per channel
  output logic                           msg_done_o   [NumChan],
  output logic      [BeatCountWidth-1:0] msg_beats_o  [NumChan],
  output logic      [MsgCountWidth-1:0]  msg_count_o  [NumChan],

  // Sticky oversize flag
  output logic                           size_err_o
);

  //////////////////////////////
  // Opcode and size decode
  //////////////////////////////

  logic                     fire      [NumChan];
  logic [BurstLenWidth-1:0] burst_len [NumChan];

  tl_chan_decode i_tl_chan_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_fire_i    (a_fire_i),
    .c_fire_i    (c_fire_i),
    .d_fire_i    (d_fire_i),
    .a_opcode_i  (a_opcode_i),
    .c_opcode_i  (c_opcode_i),
    .d_opcode_i  (d_opcode_i),
    .a_size_i    (a_size_i),
    .c_size_i    (c_size_i),
    .d_size_i    (d_size_i),
    .fire_o      (fire),
    .burst_len_o (burst_len),
    .size_err_o  (size_err_o)
  );

  //////////////////////////////
  // Beat trackers
  //////////////////////////////

  // Channels are independent, so each gets its own tracker
  for (genvar c = 0; c < NumChan; c++) begin : g_tracker
    tl_beat_tracker i_tl_beat_tracker (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .fire_i  (fire[c]),
      .len_i   (burst_len[c]),
      .idx_o   (beat_idx_o[c]),
      .left_o  (beat_left_o[c]),
      .first_o (beat_first_o[c]),
      .last_o  (beat_last_o[c])
    );
  end

  //////////////////////////////
  // Message reporting
  //////////////////////////////

  tl_msg_counter i_tl_msg_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fire_i      (fire),
    .last_i      (beat_last_o),
    .len_i       (burst_len),
    .msg_done_o  (msg_done_o),
    .msg_beats_o (msg_beats_o),
    .msg_count_o (msg_count_o)
  );

endmodule

`default_nettype wire

/* design/tl_chan_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tl_chan_decode import tl_mon_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,

  // Beat strobes, one per channel
  input  wire logic                     a_fire_i,
  input  wire logic                     c_fire_i,
  input  wire logic                     d_fire_i,

  // Message header fields, valid while the matching fire is high
  input  wire logic [OpcodeWidth-1:0]   a_opcode_i,
  input  wire logic [OpcodeWidth-1:0]   c_opcode_i,
  input  wire logic [OpcodeWidth-1:0]   d_opcode_i,
  input  wire logic [SizeWidth-1:0]     a_size_i,
  input  wire logic [SizeWidth-1:0]     c_size_i,
  input  wire logic [SizeWidth-1:0]     d_size_i,

  // Channel-indexed strobes and burst lengths (beats minus one)
  output logic                          fire_o      [NumChan],
  output logic [BurstLenWidth-1:0]      burst_len_o [NumChan],

  // Sticky flag for a size above MaxSize
  output logic                          size_err_o
);

  // Burst length of one message, expressed as beats minus one
  // Sizes above MaxSize are clamped, so an oversized message still has a defined length
  function automatic logic [BurstLenWidth-1:0] burst_len(input logic           has_data,
                                                         input logic [SizeWidth-1:0] size);
    logic [SizeWidth-1:0]      clamped;
    logic [BeatCountWidth-1:0] beats;
    clamped = (size > SizeWidth'(MaxSize)) ? SizeWidth'(MaxSize) : size;
    // Messages without data and messages that fit in one beat are single-beat
    if (!has_data || clamped <= SizeWidth'(NonBurstSize)) begin
      return '0;
    end
    beats = BeatCountWidth'(1) << (clamped - SizeWidth'(NonBurstSize));
    return BurstLenWidth'(beats - 1'b1);
  endfunction

  //////////////////////////////
  // Data rule per channel
  //////////////////////////////

  // On A, PutFull, PutPartial, Arithmetic and Logical carry data
  // Those are exactly the opcodes below 4
  logic a_has_data;
  // On C and D, opcode bit 0 marks the data-carrying variant
  logic c_has_data;
  logic d_has_data;

  assign a_has_data = a_opcode_i < OpcodeWidth'(4);
  assign c_has_data = c_opcode_i[0];
  assign d_has_data = d_opcode_i[0];

  //////////////////////////////
  // Channel-indexed outputs
  //////////////////////////////

  assign fire_o[ChanA] = a_fire_i;
  assign fire_o[ChanC] = c_fire_i;
  assign fire_o[ChanD] = d_fire_i;

  assign burst_len_o[ChanA] = burst_len(a_has_data, a_size_i);
  assign burst_len_o[ChanC] = burst_len(c_has_data, c_size_i);
  assign burst_len_o[ChanD] = burst_len(d_has_data, d_size_i);

  //////////////////////////////
  // Oversize flag
  //////////////////////////////

  // A beat fired with a size the monitor cannot represent
  // Only fired beats count, since the size is meaningless otherwise
  logic oversize;
  logic size_err_q;

  assign oversize = (a_fire_i && a_size_i > SizeWidth'(MaxSize)) ||
                    (c_fire_i && c_size_i > SizeWidth'(MaxSize)) ||
                    (d_fire_i && d_size_i > SizeWidth'(MaxSize));

  // Once set, the flag holds until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      size_err_q <= 1'b0;
    end else if (oversize) begin
      size_err_q <= 1'b1;
    end
  end

  assign size_err_o = size_err_q;

endmodule

`default_nettype wire

/* design/tl_mon_pkg.sv */
`default_nettype none

package tl_mon_pkg;

  //////////////////////////////
  // Link geometry
  //////////////////////////////

  // Data bits carried by one beat on the link
  localparam int unsigned DataWidth = 64;

  // Bytes carried by one beat
  localparam int unsigned DataBytes = DataWidth / 8;

  // A size field holds the base-two log of the message byte count
  localparam int unsigned SizeWidth = 3;

  // Opcode field width, shared by the A, C and D channels
  localparam int unsigned OpcodeWidth = 3;

  //////////////////////////////
  // Burst geometry
  //////////////////////////////

  // Largest size that still fits in a single beat
  localparam int unsigned NonBurstSize = $clog2(DataBytes);

  // Largest supported size, 64 bytes
  // Anything larger is flagged and then tracked as if it were this size
  localparam int unsigned MaxSize = 6;

  // Beats in the largest burst
  localparam int unsigned MaxBurstLen = 2 ** (MaxSize - NonBurstSize);

  // Width of the len, index and left fields
  // These hold at most MaxBurstLen minus one
  localparam int unsigned BurstLenWidth = $clog2(MaxBurstLen);

  //////////////////////////////
  // Channel indices
  //////////////////////////////

  // Number of channels with a beat tracker
  // The B channel is single-beat only and is not tracked
  localparam int unsigned NumChan = 3;

  // Requests
  localparam int unsigned ChanA = 0;

  // Releases
  localparam int unsigned ChanC = 1;

  // Grants and access responses
  localparam int unsigned ChanD = 2;

  //////////////////////////////
  // Counter widths
  //////////////////////////////

  // Completed messages per channel, saturating
  localparam int unsigned MsgCountWidth = 16;

  // Beat count of a finished message
  // One bit wider than the len field so that MaxBurstLen itself fits
  localparam int unsigned BeatCountWidth = BurstLenWidth + 1;

endpackage

`default_nettype wire

/* design/tl_msg_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tl_msg_counter import tl_mon_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  // Per-channel beat strobe and last-beat indication from the trackers
  input  wire logic                      fire_i      [NumChan],
  input  wire logic                      last_i      [NumChan],
  // Burst length of the beat on the wires, beats minus one
  input  wire logic [BurstLenWidth-1:0]  len_i       [NumChan],

  // One-cycle strobe, the cycle after a message's last beat
  output logic                           msg_done_o  [NumChan],
  // Beats in the message just finished, valid with msg_done_o
  output logic      [BeatCountWidth-1:0] msg_beats_o [NumChan],
  // Finished messages per channel, saturating at all ones
  output logic      [MsgCountWidth-1:0]  msg_count_o [NumChan]
);

  //////////////////////////////
  // Per-channel lanes
  //////////////////////////////

  // Every channel has its own lane, so completions on several channels in
  // the same cycle are all reported without any arbitration

  logic                      done_q  [NumChan];
  logic [BeatCountWidth-1:0] beats_q [NumChan];
  logic [MsgCountWidth-1:0]  count_q [NumChan];

  for (genvar c = 0; c < NumChan; c++) begin : g_lane

    // The last beat of a message is transferred in this cycle
    logic msg_end;

    assign msg_end = fire_i[c] && last_i[c];

    // Done strobe and message counter
    // The counter moves on the same edge that raises the strobe, so both
    // show the new message in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        done_q[c]  <= 1'b0;
        count_q[c] <= '0;
      end else begin
        done_q[c] <= msg_end;
        // Hold at all ones once the counter is full
        if (msg_end && !(&count_q[c])) begin
          count_q[c] <= count_q[c] + 1'b1;
        end
      end
    end

    // Beat count of the finished message
    // It only means something while the done strobe is high
    always_ff @(posedge clk_i) begin
      if (msg_end) begin
        beats_q[c] <= BeatCountWidth'(len_i[c]) + 1'b1;
      end
    end

    assign msg_done_o[c]  = done_q[c];
    assign msg_beats_o[c] = beats_q[c];
    assign msg_count_o[c] = count_q[c];

  end

endmodule

`default_nettype wire

/* testbench/tb_tl_burst_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tl_burst_monitor import tl_mon_pkg::*; ();

  // Cycles of randomized traffic in the mixed test
  localparam int RandCycles = 400;
  // Reset, the directed tests and the random test added up
  localparam int TestCycles = 8 + 4 + 9 + 13 + RandCycles + 10 + 22;
  localparam int TimeoutCycles = TestCycles * 2 + 100;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic clk_i;
  logic rst_ni;
  logic a_fire;
  logic c_fire;
  logic d_fire;
  logic [OpcodeWidth-1:0] a_opcode;
  logic [OpcodeWidth-1:0] c_opcode;
  logic [OpcodeWidth-1:0] d_opcode;
  logic [SizeWidth-1:0] a_size;
  logic [SizeWidth-1:0] c_size;
  logic [SizeWidth-1:0] d_size;
  logic [BurstLenWidth-1:0] beat_idx [NumChan];
  logic [BurstLenWidth-1:0] beat_left [NumChan];
  logic beat_first [NumChan];
  logic beat_last [NumChan];
  logic msg_done [NumChan];
  logic [BeatCountWidth-1:0] msg_beats [NumChan];
  logic [MsgCountWidth-1:0] msg_count [NumChan];
  logic size_err;

  tl_burst_monitor i_tl_burst_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_fire_i     (a_fire),
    .c_fire_i     (c_fire),
    .d_fire_i     (d_fire),
    .a_opcode_i   (a_opcode),
    .a_size_i     (a_size),
    .c_opcode_i   (c_opcode),
    .c_size_i     (c_size),
    .d_opcode_i   (d_opcode),
    .d_size_i     (d_size),
    .beat_idx_o   (beat_idx),
    .beat_left_o  (beat_left),
    .beat_first_o (beat_first),
    .beat_last_o  (beat_last),
    .msg_done_o   (msg_done),
    .msg_beats_o  (msg_beats),
    .msg_count_o  (msg_count),
    .size_err_o   (size_err)
  );

  // 4 ns clock period
  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // Stimulus and model state
  //////////////////////////////

  // Requested inputs per channel, copied onto the DUT pins at each falling edge
  logic fire_r [NumChan];
  logic [OpcodeWidth-1:0] op_r [NumChan];
  logic [SizeWidth-1:0] size_r [NumChan];

  // Position of the next beat in its message, zero between messages
  int pos [NumChan];
  // Beats of the message in progress, fixed at its first beat
  int msg_len [NumChan];
  // Messages completed so far per channel
  int done_cnt [NumChan];
  // Expected completion report for the following cycle
  logic exp_done [NumChan];
  int exp_beats [NumChan];
  logic exp_err;

  int cycles;

  // Watchdog so that a stuck run still ends
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  // A carries data for opcodes 0 to 3, C and D when opcode bit 0 is set
  function automatic bit carries_data(int ch, logic [OpcodeWidth-1:0] op);
    if (ch == ChanA) begin
      return op < 4;
    end
    return op[0];
  endfunction

  // Number of beats of a message, with sizes above the largest one clamped
  function automatic int message_beats(int ch, logic [OpcodeWidth-1:0] op,
                                       logic [SizeWidth-1:0] size);
    int sz;
    sz = (size > MaxSize) ? MaxSize : int'(size);
    if (!carries_data(ch, op) || sz <= NonBurstSize) begin
      return 1;
    end
    return 1 << (sz - NonBurstSize);
  endfunction

  //////////////////////////////
  // Failure reporting and checks
  //////////////////////////////

  task automatic fail_run(string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_beat(int ch, logic [BurstLenWidth-1:0] idx,
                            logic [BurstLenWidth-1:0] left, logic first, logic last);
    if (beat_idx[ch] !== idx) begin
      report_mismatch($sformatf("beat_idx_o[%0d]", ch), 32'(beat_idx[ch]), 32'(idx));
    end
    if (beat_left[ch] !== left) begin
      report_mismatch($sformatf("beat_left_o[%0d]", ch), 32'(beat_left[ch]), 32'(left));
    end
    if (beat_first[ch] !== first) begin
      report_mismatch($sformatf("beat_first_o[%0d]", ch), 32'(beat_first[ch]), 32'(first));
    end
    if (beat_last[ch] !== last) begin
      report_mismatch($sformatf("beat_last_o[%0d]", ch), 32'(beat_last[ch]), 32'(last));
    end
  endtask

  task automatic check_done(int ch, logic done, logic [BeatCountWidth-1:0] beats,
                            logic [MsgCountWidth-1:0] count);
    if (msg_done[ch] !== done) begin
      report_mismatch($sformatf("msg_done_o[%0d]", ch), 32'(msg_done[ch]), 32'(done));
    end
    // The beat count only carries meaning next to a done strobe
    if (done && msg_beats[ch] !== beats) begin
      report_mismatch($sformatf("msg_beats_o[%0d]", ch), 32'(msg_beats[ch]), 32'(beats));
    end
    if (msg_count[ch] !== count) begin
      report_mismatch($sformatf("msg_count_o[%0d]", ch), 32'(msg_count[ch]), 32'(count));
    end
  endtask

  task automatic check_err(logic err);
    if (size_err !== err) begin
      report_mismatch("size_err_o", 32'(size_err), 32'(err));
    end
  endtask

  //////////////////////////////
  // Cycle driver
  //////////////////////////////

  // Drives one cycle, checks every output against the model, then advances it
  task automatic drive_cycle();
    int beats;
    int e_idx;
    int e_left;
    @(negedge clk_i);
    a_fire = fire_r[ChanA];
    a_opcode = op_r[ChanA];
    a_size = size_r[ChanA];
    c_fire = fire_r[ChanC];
    c_opcode = op_r[ChanC];
    c_size = size_r[ChanC];
    d_fire = fire_r[ChanD];
    d_opcode = op_r[ChanD];
    d_size = size_r[ChanD];
    #1;
    // Registered results belong to the cycle before
    check_err(exp_err);
    for (int ch = 0; ch < NumChan; ch++) begin
      check_done(ch, exp_done[ch], BeatCountWidth'(exp_beats[ch]),
                 MsgCountWidth'(done_cnt[ch]));
      exp_done[ch] = 1'b0;
    end
    for (int ch = 0; ch < NumChan; ch++) begin
      beats = (pos[ch] == 0) ? message_beats(ch, op_r[ch], size_r[ch]) : msg_len[ch];
      e_idx = pos[ch];
      e_left = beats - 1 - pos[ch];
      check_beat(ch, BurstLenWidth'(e_idx), BurstLenWidth'(e_left),
                 pos[ch] == 0, e_left == 0);
      if (fire_r[ch]) begin
        if (size_r[ch] > MaxSize) begin
          exp_err = 1'b1;
        end
        msg_len[ch] = beats;
        pos[ch]++;
        if (pos[ch] == beats) begin
          pos[ch] = 0;
          done_cnt[ch]++;
          exp_done[ch] = 1'b1;
          exp_beats[ch] = beats;
        end
      end
    end
  endtask

  task automatic idle_cycle();
    for (int ch = 0; ch < NumChan; ch++) begin
      fire_r[ch] = 1'b0;
    end
    drive_cycle();
  endtask

  // Random fires on all channels, new headers only between messages
  task automatic random_cycles(int n);
    repeat (n) begin
      for (int ch = 0; ch < NumChan; ch++) begin
        if (pos[ch] == 0) begin
          op_r[ch] = OpcodeWidth'($urandom % 8);
          size_r[ch] = SizeWidth'($urandom % (MaxSize + 1));
        end
        fire_r[ch] = ($urandom % 3) != 0;
      end
      drive_cycle();
    end
  endtask

  // Fires the remaining beats of every open message with the headers held
  // A burst never has more than MaxBurstLen beats, so this many cycles suffice
  task automatic finish_messages();
    repeat (MaxBurstLen) begin
      for (int ch = 0; ch < NumChan; ch++) begin
        fire_r[ch] = pos[ch] != 0;
      end
      drive_cycle();
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic single_beat_messages();
    // Idle after reset shows first on every channel and no done
    idle_cycle();
    // Get with size 6 on A and a C message without data, fired together
    op_r[ChanA] = 3'd4;
    size_r[ChanA] = 3'd6;
    op_r[ChanC] = 3'd0;
    size_r[ChanC] = 3'd6;
    fire_r[ChanA] = 1'b1;
    fire_r[ChanC] = 1'b1;
    drive_cycle();
    idle_cycle();
    idle_cycle();
  endtask

  task automatic full_a_burst();
    op_r[ChanA] = 3'd0;
    size_r[ChanA] = 3'd6;
    repeat (MaxBurstLen) begin
      fire_r[ChanA] = 1'b1;
      drive_cycle();
    end
    idle_cycle();
  endtask

  task automatic interleaved_c_d();
    // C fires 4 times and D twice, each with gaps of its own
    logic [11:0] c_pat;
    logic [11:0] d_pat;
    c_pat = 12'b0100_1000_0101;
    d_pat = 12'b0010_0000_0100;
    op_r[ChanC] = 3'd5;
    size_r[ChanC] = 3'd5;
    op_r[ChanD] = 3'd1;
    size_r[ChanD] = 3'd4;
    for (int i = 0; i < 12; i++) begin
      fire_r[ChanA] = 1'b0;
      fire_r[ChanC] = c_pat[i];
      fire_r[ChanD] = d_pat[i];
      drive_cycle();
    end
    idle_cycle();
  endtask

  task automatic message_counts();
    // Close whatever the random traffic left open, then let the reports settle
    // The counts themselves are compared with the model on every cycle
    finish_messages();
    idle_cycle();
    idle_cycle();
    for (int ch = 0; ch < NumChan; ch++) begin
      if (done_cnt[ch] == 0) begin
        fail_run($sformatf("channel %0d completed no message at all", ch));
      end
    end
  endtask

  task automatic oversize_flag();
    // Size 7 with data on D, tracked as a full burst
    op_r[ChanD] = 3'd1;
    size_r[ChanD] = 3'd7;
    repeat (MaxBurstLen) begin
      fire_r[ChanA] = 1'b0;
      fire_r[ChanC] = 1'b0;
      fire_r[ChanD] = 1'b1;
      drive_cycle();
    end
    idle_cycle();
    // Legal traffic afterwards must leave the flag set
    random_cycles(12);
    idle_cycle();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(39625));
    cycles = 0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    a_fire = 1'b0;
    c_fire = 1'b0;
    d_fire = 1'b0;
    a_opcode = '0;
    c_opcode = '0;
    d_opcode = '0;
    a_size = '0;
    c_size = '0;
    d_size = '0;
    exp_err = 1'b0;
    for (int ch = 0; ch < NumChan; ch++) begin
      fire_r[ch] = 1'b0;
      op_r[ch] = '0;
      size_r[ch] = '0;
      pos[ch] = 0;
      msg_len[ch] = 1;
      done_cnt[ch] = 0;
      exp_done[ch] = 1'b0;
      exp_beats[ch] = 0;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    single_beat_messages();
    full_a_burst();
    interleaved_c_d();
    random_cycles(RandCycles);
    message_counts();
    oversize_flag();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
